// ==== rvIsaPkg.sv ====
package rvIsaPkg;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        opOp    = 7'b0110011,
        opImm   = 7'b0010011,
        opLoad  = 7'b0000011,
        opStore = 7'b0100011
    } opcodeT;

    // Internal ALU operations, not an ISA field
    typedef enum logic [3:0] {
        aluAdd = 4'd0,
        aluSub = 4'd1,
        aluAnd = 4'd2,
        aluOr  = 4'd3,
        aluXor = 4'd4,
        aluSlt = 4'd5,
        aluSll = 4'd6,
        aluSrl = 4'd7
    } aluOpT;

    // funct3 codes for OP and OP-IMM
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Sll    = 3'b001;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3Srl    = 3'b101;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;

    // Only full-word loads and stores
    localparam logic [2:0] f3Word   = 3'b010;

endpackage

// ==== cpuCfgPkg.sv ====
package cpuCfgPkg;

    localparam int instDepth = 64; // Words
    localparam int dataDepth = 64; // Words
    localparam int instAddrW = 6;
    localparam int dataAddrW = 6;
    localparam int xlen      = 32;

    // Decode to execute
    typedef struct packed {
        logic            legal;
        logic            regWrite;
        logic            aluSrcImm;  // Second operand is the immediate
        logic            memRead;
        logic            memWrite;
        rvIsaPkg::aluOpT aluOp;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [4:0]      rd;
        logic [xlen-1:0] imm;
    } decodedT;

    // Execute to memory
    typedef struct packed {
        logic [xlen-1:0] aluResult;
        logic [xlen-1:0] storeData;
    } execT;

    // Architectural effect of one instruction
    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [4:0]      rd;         // Zero when nothing is written
        logic [xlen-1:0] wdata;
        logic            store;
        logic [xlen-1:0] storeAddr;
        logic [xlen-1:0] storeData;
    } commitT;

endpackage

// ==== instMem.sv ====
`timescale 1ns/100ps

module instMem (
    input  logic                           CLK,
    input  logic                           progWe,
    input  logic [cpuCfgPkg::instAddrW-1:0] progAddr,
    input  logic [31:0]                    progData,
    input  logic [31:0]                    pc,
    output logic [31:0]                    inst
);

    logic [31:0] mem [cpuCfgPkg::instDepth];

    // Program load port
    always_ff @(posedge CLK) begin
        if (progWe) begin
            mem[progAddr] <= progData;
        end
    end

    // Word index from pc, upper bits ignored so fetch wraps
    assign inst = mem[pc[cpuCfgPkg::instAddrW+1:2]];

endmodule

// ==== decodeStage.sv ====
`timescale 1ns/100ps

module decodeStage (
    input  logic [31:0]        inst,
    output cpuCfgPkg::decodedT dec
);

    rvIsaPkg::opcodeT opcode;
    logic [2:0]       funct3;
    logic             funct7b30;
    logic [31:0]      immI;
    logic [31:0]      immS;

    assign opcode    = rvIsaPkg::opcodeT'(inst[6:0]);
    assign funct3    = inst[14:12];
    assign funct7b30 = inst[30];

    // Sign-extended immediates
    assign immI = {{20{inst[31]}}, inst[31:20]};
    assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};

    always_comb begin
        dec       = '0;
        dec.rs1   = inst[19:15];
        dec.rs2   = inst[24:20];
        dec.rd    = inst[11:7];
        dec.imm   = immI;
        dec.aluOp = rvIsaPkg::aluAdd;

        case (opcode)
            rvIsaPkg::opOp: begin
                dec.legal    = 1'b1;
                dec.regWrite = 1'b1;
                case (funct3)
                    rvIsaPkg::f3AddSub: dec.aluOp = funct7b30 ? rvIsaPkg::aluSub : rvIsaPkg::aluAdd;
                    rvIsaPkg::f3Sll: begin
                        dec.aluOp = rvIsaPkg::aluSll;
                        dec.legal = !funct7b30;
                    end
                    rvIsaPkg::f3Srl: begin
                        dec.aluOp = rvIsaPkg::aluSrl;
                        dec.legal = !funct7b30; // sra not supported
                    end
                    rvIsaPkg::f3Slt: dec.aluOp = rvIsaPkg::aluSlt;
                    rvIsaPkg::f3Xor: dec.aluOp = rvIsaPkg::aluXor;
                    rvIsaPkg::f3Or:  dec.aluOp = rvIsaPkg::aluOr;
                    rvIsaPkg::f3And: dec.aluOp = rvIsaPkg::aluAnd;
                    default:         dec.legal = 1'b0;
                endcase
            end
            rvIsaPkg::opImm: begin
                dec.legal     = 1'b1;
                dec.regWrite  = 1'b1;
                dec.aluSrcImm = 1'b1;
                case (funct3)
                    rvIsaPkg::f3AddSub: dec.aluOp = rvIsaPkg::aluAdd; // No subi
                    rvIsaPkg::f3Slt:    dec.aluOp = rvIsaPkg::aluSlt;
                    rvIsaPkg::f3Xor:    dec.aluOp = rvIsaPkg::aluXor;
                    rvIsaPkg::f3Or:     dec.aluOp = rvIsaPkg::aluOr;
                    rvIsaPkg::f3And:    dec.aluOp = rvIsaPkg::aluAnd;
                    default:            dec.legal = 1'b0; // Immediate shifts left out
                endcase
            end
            rvIsaPkg::opLoad: begin
                dec.legal     = (funct3 == rvIsaPkg::f3Word);
                dec.regWrite  = 1'b1;
                dec.aluSrcImm = 1'b1;
                dec.memRead   = 1'b1;
            end
            rvIsaPkg::opStore: begin
                dec.legal     = (funct3 == rvIsaPkg::f3Word);
                dec.aluSrcImm = 1'b1;
                dec.memWrite  = 1'b1;
                dec.imm       = immS;
            end
            default: dec.legal = 1'b0;
        endcase

        // Nothing may commit from an illegal word
        if (!dec.legal) begin
            dec.regWrite = 1'b0;
            dec.memRead  = 1'b0;
            dec.memWrite = 1'b0;
        end
    end

endmodule

// ==== regFile.sv ====
`timescale 1ns/100ps

module regFile (
    input  logic        CLK,
    input  logic        RST,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic [4:0]  rd,
    input  logic [31:0] wdata,
    input  logic        we,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2
);

    logic [31:0] regs [32];

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin // x0 stays zero
            regs[rd] <= wdata;
        end
    end

    assign rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// ==== executeStage.sv ====
`timescale 1ns/100ps

module executeStage (
    input  cpuCfgPkg::decodedT dec,
    input  logic [31:0]        rdata1,
    input  logic [31:0]        rdata2,
    output cpuCfgPkg::execT    ex
);

    logic [31:0] opA;
    logic [31:0] opB;
    logic [4:0]  shamt;

    assign opA   = rdata1;
    assign opB   = dec.aluSrcImm ? dec.imm : rdata2;
    assign shamt = opB[4:0];

    always_comb begin
        // Store data always comes from rs2
        ex.storeData = rdata2;
        case (dec.aluOp)
            rvIsaPkg::aluAdd: ex.aluResult = opA + opB;
            rvIsaPkg::aluSub: ex.aluResult = opA - opB;
            rvIsaPkg::aluAnd: ex.aluResult = opA & opB;
            rvIsaPkg::aluOr:  ex.aluResult = opA | opB;
            rvIsaPkg::aluXor: ex.aluResult = opA ^ opB;
            rvIsaPkg::aluSlt: ex.aluResult = {31'd0, $signed(opA) < $signed(opB)};
            rvIsaPkg::aluSll: ex.aluResult = opA << shamt;
            rvIsaPkg::aluSrl: ex.aluResult = opA >> shamt; // Logical
            default:          ex.aluResult = '0;
        endcase
    end

endmodule

// ==== memStage.sv ====
`timescale 1ns/100ps

module memStage (
    input  logic               CLK,
    input  logic               RST,
    input  logic               enable,
    input  cpuCfgPkg::decodedT dec,
    input  cpuCfgPkg::execT    ex,
    output logic [31:0]        wdata,
    output logic               regWe,
    output logic               storeWe
);

    logic [31:0]                     mem [cpuCfgPkg::dataDepth];
    logic [cpuCfgPkg::dataAddrW-1:0] wordAddr;
    logic [31:0]                     loadData;

    // Word address, wraps in the array
    assign wordAddr = ex.aluResult[cpuCfgPkg::dataAddrW+1:2];

    assign storeWe = enable && dec.memWrite;
    assign regWe   = enable && dec.regWrite;

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 0; i < cpuCfgPkg::dataDepth; i++) begin
                mem[i] <= '0;
            end
        end else if (storeWe) begin
            mem[wordAddr] <= ex.storeData;
        end
    end

    assign loadData = mem[wordAddr];

    // Write-back select
    assign wdata = dec.memRead ? loadData : ex.aluResult;

endmodule

// ==== singleCpu.sv ====
`timescale 1ns/100ps

module singleCpu (
    input  logic                            CLK,
    input  logic                            RST,
    input  logic                            run,
    input  logic                            progWe,
    input  logic [cpuCfgPkg::instAddrW-1:0] progAddr,
    input  logic [31:0]                     progData,
    output cpuCfgPkg::commitT               commit
);

    logic [31:0]        pc;
    logic [31:0]        inst;
    logic [31:0]        rdata1;
    logic [31:0]        rdata2;
    logic [31:0]        wdata;
    logic               regWe;
    logic               storeWe;
    logic               enable;
    cpuCfgPkg::decodedT dec;
    cpuCfgPkg::execT    ex;

    // Illegal words still advance pc
    always_ff @(posedge CLK) begin
        if (RST) begin
            pc <= '0;
        end else if (run) begin
            pc <= pc + 32'd4;
        end
    end

    assign enable = run && !RST && dec.legal;

    instMem uInstMem (
        .CLK(CLK), .progWe(progWe), .progAddr(progAddr), .progData(progData),
        .pc(pc), .inst(inst)
    );

    decodeStage uDecode (.inst(inst), .dec(dec));

    regFile uRegFile (
        .CLK(CLK), .RST(RST), .rs1(dec.rs1), .rs2(dec.rs2), .rd(dec.rd),
        .wdata(wdata), .we(regWe), .rdata1(rdata1), .rdata2(rdata2)
    );

    executeStage uExecute (.dec(dec), .rdata1(rdata1), .rdata2(rdata2), .ex(ex));

    memStage uMem (
        .CLK(CLK), .RST(RST), .enable(enable), .dec(dec), .ex(ex),
        .wdata(wdata), .regWe(regWe), .storeWe(storeWe)
    );

    always_comb begin
        commit       = '0;
        commit.valid = enable;
        commit.pc    = pc;
        if (regWe && dec.rd != 5'd0) begin // x0 writes show as no write
            commit.rd    = dec.rd;
            commit.wdata = wdata;
        end
        if (storeWe) begin
            commit.store     = 1'b1;
            commit.storeAddr = ex.aluResult;
            commit.storeData = ex.storeData;
        end
    end

endmodule

// ==== singleCpu_sva.sv ====
`timescale 1ns/100ps

module singleCpuSva (
    input logic              CLK,
    input logic              RST,
    input logic              run,
    input cpuCfgPkg::commitT commit,
    input logic [31:0]       pc
);

    int failCount;

    initial failCount = 0;

    assert property (@(posedge CLK) RST |-> !commit.valid)
        else begin
            $error("commit valid asserted during reset");
            failCount++;
        end

    // No register shown without a commit
    assert property (@(posedge CLK) !commit.valid |-> commit.rd == 5'd0)
        else begin
            $error("commit rd nonzero while valid is low");
            failCount++;
        end

    assert property (@(posedge CLK) !RST && run |=> pc == $past(pc) + 32'd4)
        else begin
            $error("pc did not advance by four while running");
            failCount++;
        end

endmodule

bind singleCpu singleCpuSva uSva (.CLK(CLK), .RST(RST), .run(run), .commit(commit), .pc(pc));

// ==== singleCpuChecker.sv ====
`timescale 1ns/100ps

module singleCpuChecker (
    input  logic                            CLK,
    input  logic                            RST,
    input  logic                            run,
    input  logic                            progWe,
    input  logic [cpuCfgPkg::instAddrW-1:0] progAddr,
    input  logic [31:0]                     progData,
    input  cpuCfgPkg::commitT               commit,
    output int                              errorCount,
    output int                              commitCount
);

    // Architectural state of the model machine
    typedef struct packed {
        logic [31:0]       pc;
        logic [31:0][31:0] regs;
        logic [63:0][31:0] mem;
    } stateT;

    logic [31:0]       prog [64]; // Copy of the loaded program
    stateT             state;
    stateT             nextState;
    cpuCfgPkg::commitT expected;

    // One instruction of the RV32I subset applied to a machine state
    function automatic cpuCfgPkg::commitT execInst(input stateT s, input logic [31:0] inst,
                                                   output stateT ns);
        cpuCfgPkg::commitT c;
        logic [31:0]       a;
        logic [31:0]       b;
        logic [31:0]       res;
        logic [31:0]       addr;
        logic              legal;
        a     = s.regs[inst[19:15]];
        b     = (inst[6:0] == 7'b0110011) ? s.regs[inst[24:20]] : {{20{inst[31]}}, inst[31:20]};
        ns    = s;
        ns.pc = s.pc + 32'd4; // Also for illegal words
        c     = '0;
        c.pc  = s.pc;
        legal = 1'b1;
        res   = '0;
        case (inst[6:0])
            7'b0110011, 7'b0010011: begin // Bit 5 set only for register-register
                case (inst[14:12])
                    3'b000:  res = (inst[5] && inst[30]) ? a - b : a + b;
                    3'b010:  res = {31'd0, $signed(a) < $signed(b)};
                    3'b100:  res = a ^ b;
                    3'b110:  res = a | b;
                    3'b111:  res = a & b;
                    3'b001: begin
                        res   = a << b[4:0];
                        legal = inst[5] && !inst[30];
                    end
                    3'b101: begin
                        res   = a >> b[4:0];
                        legal = inst[5] && !inst[30];
                    end
                    default: legal = 1'b0;
                endcase
            end
            7'b0000011: begin
                addr  = a + b;
                legal = (inst[14:12] == 3'b010);
                res   = s.mem[addr[7:2]];
            end
            7'b0100011: begin
                addr  = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
                legal = (inst[14:12] == 3'b010);
                if (legal) begin
                    c.store           = 1'b1;
                    c.storeAddr       = addr;
                    c.storeData       = s.regs[inst[24:20]];
                    ns.mem[addr[7:2]] = c.storeData;
                end
            end
            default: legal = 1'b0;
        endcase
        c.valid = legal;
        if (legal && inst[6:0] != 7'b0100011 && inst[11:7] != 5'd0) begin
            c.rd                = inst[11:7];
            c.wdata             = res;
            ns.regs[inst[11:7]] = res;
        end
        return c;
    endfunction

    initial begin
        errorCount  = 0;
        commitCount = 0;
    end

    // Commit is settled at the falling edge
    always @(negedge CLK) begin
        if (RST) begin
            state = '0;
            if (commit.valid !== 1'b0) begin
                $display("Mismatch at %0t: commit valid while in reset", $time);
                errorCount++;
            end
        end else begin
            expected    = '0;
            expected.pc = state.pc; // Held pc while stopped
            if (run) begin
                expected = execInst(state, prog[state.pc[7:2]], nextState);
                state    = nextState;
            end
            if (commit !== expected) begin
                $display("Mismatch at %0t: pc %h expected v%b rd %0d wd %h st %b %h %h,",
                         $time, expected.pc, expected.valid, expected.rd, expected.wdata,
                         expected.store, expected.storeAddr, expected.storeData,
                         " got v%b rd %0d wd %h st %b %h %h",
                         commit.valid, commit.rd, commit.wdata, commit.store,
                         commit.storeAddr, commit.storeData);
                errorCount++;
            end
            if (commit.valid === 1'b1) begin
                commitCount++;
            end
        end
        if (progWe) begin
            prog[progAddr] = progData; // Lands in the DUT at the next rising edge
        end
    end

endmodule

// ==== singleCpuTb.sv ====
`timescale 1ns/100ps

module singleCpuTb;

    localparam int numLegal  = 48;
    localparam int progLen   = 52; // Legal words plus four illegal ones
    localparam int runCycles = numLegal + 16;

    logic                            CLK;
    logic                            RST;
    logic                            run;
    logic                            progWe;
    logic [cpuCfgPkg::instAddrW-1:0] progAddr;
    logic [31:0]                     progData;
    cpuCfgPkg::commitT               commit;
    int                              errorCount;
    int                              commitCount;
    int                              otherErrors;
    int                              assertErrors;
    int                              cycles;
    logic [31:0]                     prog [64];

    function automatic logic [31:0] encodeR(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encodeI(input logic [11:0] imm, input logic [2:0] f3,
                                           input logic [4:0] rd, rs1, input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] encodeS(input logic [11:0] imm, input logic [4:0] rs2, rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    // Registers x0..x7 only, so results feed later instructions
    function automatic logic [31:0] randomLegal();
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] off;
        f3  = 3'($urandom % 8);
        rd  = 5'($urandom % 8);
        rs1 = 5'($urandom % 8);
        rs2 = 5'($urandom % 8);
        off = 12'(($urandom % 8) * 4 - ($urandom % 2) * 256); // Wraps to the same word
        case ($urandom % 4)
            0: return encodeR((f3 == 3'd0 && $urandom % 2 == 1) ? 7'b0100000 : 7'd0,
                              (f3 == 3'd3) ? 3'd0 : f3, rd, rs1, rs2);
            1: return encodeI(12'($urandom), (f3[0] && f3 != 3'd7) ? 3'd0 : f3, rd, rs1,
                              7'b0010011);
            2: return encodeI(off, 3'b010, rd, 5'd0, 7'b0000011);
            default: return encodeS(off, rs2, 5'd0);
        endcase
    endfunction

    task buildProgram();
        prog[0] = encodeI(12'(-1234), 3'b000, 5'd1, 5'd0, 7'b0010011);
        prog[1] = encodeI(12'd77, 3'b000, 5'd2, 5'd0, 7'b0010011);
        prog[2] = encodeI(12'(-1), 3'b010, 5'd3, 5'd1, 7'b0010011); // Negative slti
        prog[3] = encodeS(12'd4, 5'd1, 5'd0);
        prog[4] = encodeI(12'(-252), 3'b010, 5'd4, 5'd0, 7'b0000011); // Same word as the sw
        prog[5] = encodeI(12'd5, 3'b000, 5'd0, 5'd2, 7'b0010011);
        prog[6] = encodeR(7'd0, 3'b000, 5'd5, 5'd0, 5'd2);
        for (int i = 7; i < 64; i++) begin
            if (i >= progLen) begin
                prog[i] = '0;
            end else if (i % 13 == 12) begin
                case (i / 13)
                    0: prog[i] = encodeI(12'd3, 3'b001, 5'd2, 5'd1, 7'b0010011); // slli
                    1: prog[i] = encodeI(12'd4, 3'b000, 5'd2, 5'd0, 7'b0000011); // lb
                    2: prog[i] = 32'h0020_8463; // beq
                    default: prog[i] = encodeR(7'b0100000, 3'b101, 5'd3, 5'd1, 5'd2); // sra
                endcase
            end else begin
                prog[i] = randomLegal();
            end
        end
    endtask

    always #2 CLK = ~CLK;

    singleCpu dut (
        .CLK(CLK), .RST(RST), .run(run), .progWe(progWe), .progAddr(progAddr),
        .progData(progData), .commit(commit)
    );

    singleCpuChecker uChecker (
        .CLK(CLK), .RST(RST), .run(run), .progWe(progWe), .progAddr(progAddr),
        .progData(progData), .commit(commit), .errorCount(errorCount),
        .commitCount(commitCount)
    );

    initial begin
        void'($urandom(32'ha16));
        CLK          = 1'b0;
        RST          = 1'b1;
        run          = 1'b1; // Held high in reset, commit must still stay low
        progWe       = 1'b0;
        progAddr     = '0;
        progData     = '0;
        otherErrors  = 0;
        assertErrors = 0;
        buildProgram();
        cycles = 0;
        while (cycles < 2) begin
            @(posedge CLK);
            cycles++;
        end
        RST <= 1'b0;
        run <= 1'b0;
        for (int i = 0; i < 64; i++) begin // Whole memory, zeros past the program
            progWe   <= 1'b1;
            progAddr <= 6'(i);
            progData <= prog[i];
            @(posedge CLK);
        end
        progWe <= 1'b0;
        run    <= 1'b1;
        cycles = 0;
        while (commitCount < numLegal && cycles < runCycles) begin
            @(posedge CLK);
            cycles++;
        end
        if (commitCount < numLegal) begin
            $display("Timeout: only %0d of %0d instructions committed", commitCount, numLegal);
            otherErrors++;
        end
        while (cycles < runCycles) begin
            @(posedge CLK);
            cycles++;
        end
        run <= 1'b0;
        for (int i = 0; i < 8; i++) begin // Stopped machine must hold
            @(posedge CLK);
        end
        assertErrors = dut.uSva.failCount;
        $display("Errors: %0d mismatches, %0d assertion, %0d other; %0d of %0d commits seen",
                 errorCount, assertErrors, otherErrors, commitCount, numLegal);
        if (errorCount == 0 && assertErrors == 0 && otherErrors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== singleCpu.f ====
rvIsaPkg.sv
cpuCfgPkg.sv
instMem.sv
decodeStage.sv
regFile.sv
executeStage.sv
memStage.sv
singleCpu.sv
singleCpu_sva.sv
singleCpuChecker.sv
singleCpuTb.sv

// ==== Bender.yml ====
package:
  name: single_cpu

sources:
  - rvIsaPkg.sv
  - cpuCfgPkg.sv
  - instMem.sv
  - decodeStage.sv
  - regFile.sv
  - executeStage.sv
  - memStage.sv
  - singleCpu.sv
  - target: test
    files:
      - singleCpu_sva.sv
      - singleCpuChecker.sv
      - singleCpuTb.sv
